// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	input xlen_t a,
	input xlen_t b,
	input alu_op_t op,
	input logic [2:0] funct3,
	output xlen_t y,
	output logic br_taken
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD:  y = a + b;
			ALU_SUB:  y = a - b;
			ALU_SLL:  y = a << shamt;
			ALU_SLT:  y = xlen_t'($signed(a) < $signed(b));
			ALU_SLTU: y = xlen_t'(a < b);
			ALU_XOR:  y = a ^ b;
			ALU_SRL:  y = a >> shamt;
			ALU_SRA:  y = $signed(a) >>> shamt;
			ALU_OR:   y = a | b;
			ALU_AND:  y = a & b;
			default:  y = '0;
		endcase
	end

	// branch condition on a, b
	always_comb begin
		case (funct3)
			F3_BEQ:  br_taken = (a == b);
			F3_BNE:  br_taken = (a != b);
			F3_BLT:  br_taken = ($signed(a) < $signed(b));
			F3_BGE:  br_taken = ($signed(a) >= $signed(b));
			F3_BLTU: br_taken = (a < b);
			F3_BGEU: br_taken = (a >= b);
			default: br_taken = 1'b0;
		endcase
	end

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	input xlen_t instr_pc,
	input instr_t instr_data,
	output logic instr_credit,
	output logic result_valid,
	output res_kind_e result_kind,
	output reg_addr_t result_rd,
	output xlen_t result_data,
	output xlen_t result_next_pc,
	input logic result_credit
);

	dec_if dec ();
	rf_if rf ();

	rv_decode u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.instr_valid(instr_valid),
		.instr_pc(instr_pc),
		.instr_data(instr_data),
		.instr_credit(instr_credit),
		.dec(dec.source)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.arst_n(arst_n),
		.rf(rf.target)
	);

	rv_execute u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.dec(dec.sink),
		.rf(rf.initiator),
		.result_valid(result_valid),
		.result_kind(result_kind),
		.result_rd(result_rd),
		.result_data(result_data),
		.result_next_pc(result_next_pc),
		.result_credit(result_credit)
	);

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode import rv_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic instr_valid,
	input xlen_t instr_pc,
	input instr_t instr_data,
	output logic instr_credit,
	dec_if.source dec
);

	localparam int AW = $clog2(`RV_IQ_DEPTH);

	xlen_t iq_pc [`RV_IQ_DEPTH];
	instr_t iq_data [`RV_IQ_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr_nxt;
	logic [AW-1:0] rd_ptr_nxt;
	iq_state_e iq_state;
	logic push;
	logic pop;

	instr_t ins;
	logic [6:0] opcode;
	logic [2:0] f3;
	logic alt;
	xlen_t imm_i, imm_s, imm_b, imm_u, imm_j, imm_sh;
	alu_op_t f3_op;

	xlen_t d_imm;
	alu_op_t d_alu_op;
	opa_sel_e d_opa;
	logic d_use_imm;
	wb_sel_e d_wb;
	logic d_write;
	res_kind_e d_kind;

	assign push = instr_valid;
	// the decode register takes the head when empty or draining
	assign pop = (iq_state != IQ_EMPTY) && (!dec.valid || !dec.hold);

	assign wr_ptr_nxt = (wr_ptr == AW'(`RV_IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
	assign rd_ptr_nxt = (rd_ptr == AW'(`RV_IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

	always_ff @(posedge clk) begin
		if (push) begin
			iq_pc[wr_ptr] <= instr_pc;
			iq_data[wr_ptr] <= instr_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			iq_state <= IQ_EMPTY;
			instr_credit <= 1'b0;
		end else begin
			instr_credit <= pop;
			if (push)
				wr_ptr <= wr_ptr_nxt;
			if (pop)
				rd_ptr <= rd_ptr_nxt;
			if (push && !pop)
				iq_state <= (wr_ptr_nxt == rd_ptr) ? IQ_FULL : IQ_PARTIAL;
			else if (pop && !push)
				iq_state <= (rd_ptr_nxt == wr_ptr) ? IQ_EMPTY : IQ_PARTIAL;
		end
	end

	// instruction fields of the queue head
	assign ins = iq_data[rd_ptr];
	assign opcode = ins[6:0];
	assign f3 = ins[14:12];
	assign alt = (ins[31:25] == F7_ALT);

	assign imm_i = {{20{ins[31]}}, ins[31:20]};
	assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	assign imm_u = {ins[31:12], 12'b0};
	assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
	assign imm_sh = {27'b0, ins[24:20]};

	always_comb begin
		unique case (f3)
			F3_ADD_SUB: f3_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
			F3_SLL:     f3_op = ALU_SLL;
			F3_SLT:     f3_op = ALU_SLT;
			F3_SLTU:    f3_op = ALU_SLTU;
			F3_XOR:     f3_op = ALU_XOR;
			F3_SRL_SRA: f3_op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:      f3_op = ALU_OR;
			F3_AND:     f3_op = ALU_AND;
		endcase
	end

	always_comb begin
		d_imm = '0;
		d_alu_op = ALU_ADD;
		d_opa = OPA_RS1;
		d_use_imm = 1'b1;
		d_wb = WB_ALU;
		d_write = 1'b0;
		d_kind = KIND_ALU;
		case (opcode)
			OPC_LUI: begin
				d_imm = imm_u;
				d_opa = OPA_ZERO;
				d_write = 1'b1;
			end
			OPC_AUIPC: begin
				d_imm = imm_u;
				d_opa = OPA_PC;
				d_write = 1'b1;
			end
			OPC_JAL: begin
				d_imm = imm_j;
				d_opa = OPA_PC;
				d_wb = WB_PC4;
				d_write = 1'b1;
				d_kind = KIND_JUMP;
			end
			OPC_JALR: begin
				d_imm = imm_i;
				d_wb = WB_PC4;
				d_write = 1'b1;
				d_kind = KIND_JUMP;
			end
			OPC_BRANCH: begin
				// alu forms the target, compare happens on rs1/rs2
				d_imm = imm_b;
				d_opa = OPA_PC;
				d_kind = KIND_BRANCH;
			end
			OPC_LOAD: begin
				d_imm = imm_i;
				d_kind = KIND_MEM;
			end
			OPC_STORE: begin
				d_imm = imm_s;
				d_kind = KIND_MEM;
			end
			OPC_OP_IMM: begin
				d_imm = (f3 == F3_SLL || f3 == F3_SRL_SRA) ? imm_sh : imm_i;
				d_alu_op = f3_op;
				d_write = 1'b1;
			end
			OPC_OP: begin
				d_alu_op = f3_op;
				d_use_imm = 1'b0;
				d_write = 1'b1;
			end
			default: d_kind = KIND_ILLEGAL;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			dec.valid <= 1'b0;
		else if (pop)
			dec.valid <= 1'b1;
		else if (!dec.hold)
			dec.valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			dec.pc <= iq_pc[rd_ptr];
			dec.rd <= d_write ? ins[11:7] : '0;
			dec.rs1 <= ins[19:15];
			dec.rs2 <= ins[24:20];
			dec.imm <= d_imm;
			dec.funct3 <= f3;
			dec.alu_op <= d_alu_op;
			dec.opa_sel <= d_opa;
			dec.use_imm <= d_use_imm;
			dec.wb_sel <= d_wb;
			dec.reg_write <= d_write;
			dec.kind <= d_kind;
		end
	end

	// host must hold a credit to send
	a_no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid |-> iq_state != IQ_FULL);

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute import rv_pkg::*; (
	input logic clk,
	input logic arst_n,
	dec_if.sink dec,
	rf_if.initiator rf,
	output logic result_valid,
	output res_kind_e result_kind,
	output reg_addr_t result_rd,
	output xlen_t result_data,
	output xlen_t result_next_pc,
	input logic result_credit
);

	localparam int CW = $clog2(`RV_RES_CREDITS + 1);

	logic [CW-1:0] res_cnt;
	logic fire;
	xlen_t opa;
	xlen_t opb;
	xlen_t alu_y;
	logic br_taken;
	xlen_t pc4;
	xlen_t next_pc;
	xlen_t wd;
	xlen_t res_data;

	// stall while the host owes us credits
	assign dec.hold = (res_cnt == '0);
	assign fire = dec.valid && !dec.hold;

	always_comb begin
		case (dec.opa_sel)
			OPA_RS1: opa = rf.rd1;
			OPA_PC:  opa = dec.pc;
			default: opa = '0;
		endcase
	end

	assign opb = dec.use_imm ? dec.imm : rf.rd2;

	rv_alu u_alu_val (
		.a(opa),
		.b(opb),
		.op(dec.alu_op),
		.funct3(dec.funct3),
		.y(alu_y),
		.br_taken()
	);

	rv_alu u_alu_cmp (
		.a(rf.rd1),
		.b(rf.rd2),
		.op(ALU_SUB),
		.funct3(dec.funct3),
		.y(),
		.br_taken(br_taken)
	);

	assign pc4 = dec.pc + 32'd4;
	assign wd = (dec.wb_sel == WB_PC4) ? pc4 : alu_y;

	always_comb begin
		next_pc = pc4;
		res_data = wd;
		case (dec.kind)
			KIND_JUMP: begin
				// jalr target drops bit 0
				next_pc = (dec.opa_sel == OPA_RS1) ? {alu_y[31:1], 1'b0} : alu_y;
			end
			KIND_BRANCH: begin
				next_pc = br_taken ? alu_y : pc4;
				res_data = '0;
			end
			KIND_MEM: res_data = alu_y;
			KIND_ILLEGAL: res_data = '0;
			default: res_data = wd;
		endcase
	end

	assign rf.ra1 = dec.rs1;
	assign rf.ra2 = dec.rs2;
	assign rf.we = fire && dec.reg_write;
	assign rf.wa = dec.rd;
	assign rf.wd = wd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
			res_cnt <= CW'(`RV_RES_CREDITS);
		end else begin
			result_valid <= fire;
			case ({fire, result_credit})
				2'b10: res_cnt <= res_cnt - 1'b1;
				2'b01: res_cnt <= res_cnt + 1'b1;
				default: res_cnt <= res_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			result_kind <= dec.kind;
			result_rd <= dec.rd;
			result_data <= res_data;
			result_next_pc <= next_pc;
		end
	end

	// out of credits, the decoded instruction waits unchanged
	a_stall_holds_instr: assert property (@(posedge clk) disable iff (!arst_n)
		dec.valid && res_cnt == '0 |=> dec.valid && $stable(dec.pc));

	// host returns no more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		res_cnt <= CW'(`RV_RES_CREDITS));

endmodule

// ==== source/rv_ifs.sv ====
`timescale 1ns/1ps

// decoded instruction, decode to execute
interface dec_if import rv_pkg::*; ();
	logic valid;
	logic hold;
	xlen_t pc;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	xlen_t imm;
	logic [2:0] funct3;
	alu_op_t alu_op;
	opa_sel_e opa_sel;
	logic use_imm;
	wb_sel_e wb_sel;
	logic reg_write;
	res_kind_e kind;

	modport source (
		output valid, pc, rd, rs1, rs2, imm, funct3, alu_op, opa_sel, use_imm, wb_sel,
		output reg_write, kind,
		input hold
	);
	modport sink (
		input valid, pc, rd, rs1, rs2, imm, funct3, alu_op, opa_sel, use_imm, wb_sel,
		input reg_write, kind,
		output hold
	);
endinterface

// register file access from execute
interface rf_if import rv_pkg::*; ();
	reg_addr_t ra1;
	reg_addr_t ra2;
	xlen_t rd1;
	xlen_t rd2;
	logic we;
	reg_addr_t wa;
	xlen_t wd;

	modport initiator (output ra1, ra2, we, wa, wd, input rd1, rd2);
	modport target (input ra1, ra2, we, wa, wd, output rd1, rd2);
endinterface

// ==== source/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// instruction queue entries, also the initial host credits
`define RV_IQ_DEPTH 4

// result credits the core holds out of reset
`define RV_RES_CREDITS 2

`endif

// ==== source/rv_pkg.sv ====
`include "rv_params.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] xlen_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] alu_op_t;

	// base opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// funct7 that selects SUB and SRA
	localparam logic [6:0] F7_ALT = 7'b0100000;

	// arithmetic funct3
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;

	typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_PC4} wb_sel_e;
	typedef enum logic [2:0] {KIND_ALU, KIND_JUMP, KIND_BRANCH, KIND_MEM, KIND_ILLEGAL} res_kind_e;
	typedef enum logic [1:0] {IQ_EMPTY, IQ_PARTIAL, IQ_FULL} iq_state_e;

endpackage

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
	input logic clk,
	input logic arst_n,
	rf_if.target rf
);

	xlen_t regs [`RV_NREGS];

	assign rf.rd1 = regs[rf.ra1];
	assign rf.rd2 = regs[rf.ra2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NREGS; i++)
				regs[i] <= '0;
		end else if (rf.we && rf.wa != '0) begin
			// x0 never written so it reads zero
			regs[rf.wa] <= rf.wd;
		end
	end

	a_wa_known: assert property (@(posedge clk) disable iff (!arst_n)
		rf.we |-> !$isunknown(rf.wa));

endmodule

// ==== testbench/tb_rv_vectors.svh ====
`ifndef TB_RV_VECTORS_SVH
`define TB_RV_VECTORS_SVH

// columns: pc, instruction, kind, rd, data, next pc
// registers after row 2: x1 = 5, x2 = -3
function automatic void load_table();
	add_row(32'h0000_0100, 32'h0050_0093, KIND_ALU, 5'd1, 32'h0000_0005, 32'h0000_0104);
	add_row(32'h0000_0104, 32'hFFD0_0113, KIND_ALU, 5'd2, 32'hFFFF_FFFD, 32'h0000_0108);
	add_row(32'h0000_0108, 32'h1234_51B7, KIND_ALU, 5'd3, 32'h1234_5000, 32'h0000_010C);
	add_row(32'h0000_010C, 32'h0000_1217, KIND_ALU, 5'd4, 32'h0000_110C, 32'h0000_0110);
	// R-type, all ten operations
	add_row(32'h0000_0110, 32'h0020_82B3, KIND_ALU, 5'd5, 32'h0000_0002, 32'h0000_0114);
	add_row(32'h0000_0114, 32'h4020_8333, KIND_ALU, 5'd6, 32'h0000_0008, 32'h0000_0118);
	add_row(32'h0000_0118, 32'h0011_23B3, KIND_ALU, 5'd7, 32'h0000_0001, 32'h0000_011C);
	add_row(32'h0000_011C, 32'h0011_3433, KIND_ALU, 5'd8, 32'h0000_0000, 32'h0000_0120);
	add_row(32'h0000_0120, 32'h0011_C4B3, KIND_ALU, 5'd9, 32'h1234_5005, 32'h0000_0124);
	add_row(32'h0000_0124, 32'h4011_5533, KIND_ALU, 5'd10, 32'hFFFF_FFFF, 32'h0000_0128);
	add_row(32'h0000_0128, 32'h0011_55B3, KIND_ALU, 5'd11, 32'h07FF_FFFF, 32'h0000_012C);
	add_row(32'h0000_012C, 32'h0010_9633, KIND_ALU, 5'd12, 32'h0000_00A0, 32'h0000_0130);
	add_row(32'h0000_0130, 32'h0011_E6B3, KIND_ALU, 5'd13, 32'h1234_5005, 32'h0000_0134);
	add_row(32'h0000_0134, 32'h0061_7733, KIND_ALU, 5'd14, 32'h0000_0008, 32'h0000_0138);
	// srai and slli
	add_row(32'h0000_0138, 32'h4011_5793, KIND_ALU, 5'd15, 32'hFFFF_FFFE, 32'h0000_013C);
	add_row(32'h0000_013C, 32'h0030_9813, KIND_ALU, 5'd16, 32'h0000_0028, 32'h0000_0140);
	// beq, bne, blt, bge, bltu, bgeu
	add_row(32'h0000_0140, 32'h0010_8863, KIND_BRANCH, 5'd0, 32'h0, 32'h0000_0150);
	add_row(32'h0000_0144, 32'h0010_9863, KIND_BRANCH, 5'd0, 32'h0, 32'h0000_0148);
	add_row(32'h0000_0148, 32'hFE11_4CE3, KIND_BRANCH, 5'd0, 32'h0, 32'h0000_0140);
	add_row(32'h0000_014C, 32'h0011_5463, KIND_BRANCH, 5'd0, 32'h0, 32'h0000_0150);
	add_row(32'h0000_0150, 32'h0220_E063, KIND_BRANCH, 5'd0, 32'h0, 32'h0000_0170);
	add_row(32'h0000_0154, 32'h0220_F063, KIND_BRANCH, 5'd0, 32'h0, 32'h0000_0158);
	// jal, then jalr to x1 + 2 with bit 0 dropped
	add_row(32'h0000_0158, 32'h1000_08EF, KIND_JUMP, 5'd17, 32'h0000_015C, 32'h0000_0258);
	add_row(32'h0000_0258, 32'h0020_8967, KIND_JUMP, 5'd18, 32'h0000_025C, 32'h0000_0006);
	add_row(32'h0000_025C, 32'h0070_0013, KIND_ALU, 5'd0, 32'h0000_0007, 32'h0000_0260);
	// lw and sw report the address only
	add_row(32'h0000_0260, 32'hFFC0_AA03, KIND_MEM, 5'd0, 32'h0000_0001, 32'h0000_0264);
	add_row(32'h0000_0264, 32'h0030_A423, KIND_MEM, 5'd0, 32'h0000_000D, 32'h0000_0268);
	add_row(32'h0000_0268, 32'h0000_000B, KIND_ILLEGAL, 5'd0, 32'h0, 32'h0000_026C);
	// x20 untouched by the load, x0 still zero
	add_row(32'h0000_026C, 32'h000A_0AB3, KIND_ALU, 5'd21, 32'h0000_0000, 32'h0000_0270);
endfunction

`endif

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

	typedef struct packed {
		xlen_t pc;
		instr_t ins;
		res_kind_e kind;
		reg_addr_t rd;
		xlen_t data;
		xlen_t next_pc;
	} vec_t;

	logic clk;
	logic arst_n;
	logic instr_valid;
	xlen_t instr_pc;
	instr_t instr_data;
	logic instr_credit;
	logic result_valid;
	res_kind_e result_kind;
	reg_addr_t result_rd;
	xlen_t result_data;
	xlen_t result_next_pc;
	logic result_credit;

	vec_t table_q[$];
	int n_rows;
	int n_sent;
	int n_results;
	int n_errors;
	int n_credit_pulses;
	int n_ret_seen;
	int n_ret_lag;
	int n_returned;
	int cycle_cnt;
	int timeout_limit;
	int seed;

	rv_core_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.instr_valid(instr_valid),
		.instr_pc(instr_pc),
		.instr_data(instr_data),
		.instr_credit(instr_credit),
		.result_valid(result_valid),
		.result_kind(result_kind),
		.result_rd(result_rd),
		.result_data(result_data),
		.result_next_pc(result_next_pc),
		.result_credit(result_credit)
	);

	function automatic void add_row(xlen_t pc, instr_t ins, res_kind_e kind, reg_addr_t rd,
		xlen_t data, xlen_t next_pc);
		vec_t row;
		row.pc = pc;
		row.ins = ins;
		row.kind = kind;
		row.rd = rd;
		row.data = data;
		row.next_pc = next_pc;
		table_q.push_back(row);
	endfunction

	`include "tb_rv_vectors.svh"

	// mostly short, now and then held back for several cycles
	function automatic int pick_delay();
		int r;
		r = $random(seed) & 32'hF;
		if (r < 3)
			return 6 + r;
		return r % 3;
	endfunction

	task automatic send_instructions();
		int i;
		i = 0;
		while (i < n_rows) begin
			@(posedge clk);
			#2;
			if (`RV_IQ_DEPTH + n_credit_pulses - n_sent > 0) begin
				instr_valid = 1'b1;
				instr_pc = table_q[i].pc;
				instr_data = table_q[i].ins;
				n_sent++;
				i++;
			end else begin
				instr_valid = 1'b0;
			end
		end
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
	endtask

	task automatic check_result();
		vec_t exp_v;
		res_kind_e exp_kind;
		int errs_before;
		assert (n_results < n_rows) else begin
			$display("extra result at %0t after all %0d rows were answered", $time, n_rows);
			n_errors++;
		end
		if (n_results >= n_rows)
			return;
		exp_v = table_q[n_results];
		exp_kind = exp_v.kind;
		errs_before = n_errors;
		// only credits back before the firing edge count
		assert (n_results + 1 <= `RV_RES_CREDITS + n_ret_lag) else begin
			$display("result at %0t was sent without a free result credit", $time);
			n_errors++;
		end
		assert (result_kind == exp_kind) else begin
			$display("[FAIL] %0t result_kind exp %s got %s", $time, exp_kind.name(),
				result_kind.name());
			n_errors++;
		end
		assert (result_rd == exp_v.rd) else begin
			$display("[FAIL] %0t result_rd exp %0d got %0d", $time, exp_v.rd, result_rd);
			n_errors++;
		end
		assert (result_data == exp_v.data) else begin
			$display("[FAIL] %0t result_data exp %h got %h", $time, exp_v.data, result_data);
			n_errors++;
		end
		assert (result_next_pc == exp_v.next_pc) else begin
			$display("[FAIL] %0t result_next_pc exp %h got %h", $time, exp_v.next_pc,
				result_next_pc);
			n_errors++;
		end
		$display("row %0d pc %h ins %h %s", n_results, exp_v.pc, exp_v.ins,
			(n_errors == errs_before) ? "ok" : "mismatch");
		n_results++;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// sampled before the DUT updates its registered outputs
	always @(posedge clk) begin
		if (arst_n) begin
			if (instr_credit)
				n_credit_pulses++;
			if (result_valid)
				check_result();
			n_ret_lag = n_ret_seen;
			if (result_credit)
				n_ret_seen++;
		end
	end

	initial begin : credit_return
		int wait_cycles;
		wait_cycles = 0;
		wait (arst_n === 1'b1);
		forever begin
			@(posedge clk);
			#2;
			result_credit = 1'b0;
			if (wait_cycles > 0) begin
				wait_cycles--;
			end else if (n_results > n_returned) begin
				result_credit = 1'b1;
				n_returned++;
				wait_cycles = pick_delay();
			end
		end
	end

	initial begin : watchdog
		wait (arst_n === 1'b1);
		while (cycle_cnt < timeout_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles with %0d of %0d results received",
			cycle_cnt, n_results, n_rows);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr_pc = '0;
		instr_data = '0;
		result_credit = 1'b0;
		seed = 32'hed6f5195;
		n_sent = 0;
		n_results = 0;
		n_errors = 0;
		n_credit_pulses = 0;
		n_ret_seen = 0;
		n_ret_lag = 0;
		n_returned = 0;
		cycle_cnt = 0;
		load_table();
		n_rows = table_q.size();
		timeout_limit = 40 * n_rows + 100;
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;
		send_instructions();
		wait (n_results == n_rows);
		// room for a stray extra result or credit pulse
		repeat (10) @(posedge clk);
		assert (n_credit_pulses == n_sent) else begin
			$display("[FAIL] %0t instr_credit pulses exp %0d got %0d", $time, n_sent,
				n_credit_pulses);
			n_errors++;
		end
		$display("rows %0d, results %0d, errors %0d", n_rows, n_results, n_errors);
		if (n_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
+incdir+testbench
source/rv_pkg.sv
source/rv_ifs.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core_top.sv
testbench/tb_rv_core.sv
